//--- design/lpif_link_defines.svh
`ifndef LPIF_LINK_DEFINES_SVH
`define LPIF_LINK_DEFINES_SVH

////////////////////
// User flit widths

`define LPIF_DATA_W      64
`define LPIF_CRC_W       8

////////////////////
// PHY channels

`define LPIF_CH_N        2
`define LPIF_CH_W        48
// Channel word minus strobe and marker
`define LPIF_CH_PAY_W    46

////////////////////
// Config map and counters

`define LPIF_CFG_ADDR_W  3
`define LPIF_DELAY_W     8
`define LPIF_CNT_W       16

`endif

//--- design/lpif_link_pkg.sv
`include "lpif_link_defines.svh"

package lpif_link_pkg;

  // User side flit, 81 bits
  typedef struct packed {
    logic [3:0]               state;
    logic [1:0]               protid;
    logic [`LPIF_DATA_W-1:0]  data;
    logic                     dvalid;
    logic [`LPIF_CRC_W-1:0]   crc;
    logic                     crc_valid;
    logic                     valid;
  } flit_t;

  // Field view of one channel word
  typedef struct packed {
    logic                       marker;
    logic                       strobe;
    logic [`LPIF_CH_PAY_W-1:0]  payload;
  } phy_fields_t;

  // Raw view goes to the pins, field view is built by the concat block
  typedef union packed {
    logic [`LPIF_CH_W-1:0]  raw;
    phy_fields_t            fields;
  } phy_word_u;

  typedef struct packed {
    logic [`LPIF_DELAY_W-1:0]  delay_x;
    logic [`LPIF_DELAY_W-1:0]  delay_xz;
    logic [`LPIF_DELAY_W-1:0]  delay_yz;
    logic [`LPIF_CH_N-1:0]     mrk_userbit;
    logic                      stb_userbit;
  } link_cfg_t;

  // Config register addresses
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_DELAY_X  = 3'd0;
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_DELAY_XZ = 3'd1;
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_DELAY_YZ = 3'd2;
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_USERBITS = 3'd3;
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_TX_COUNT = 3'd4;
  localparam logic [`LPIF_CFG_ADDR_W-1:0] CFG_RX_COUNT = 3'd5;

endpackage

//--- design/lpif_link_config.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_link_config (
  input  logic                          clk_wr,
  input  logic                          reset,
  input  logic                          cfg_wr,
  input  logic [`LPIF_CFG_ADDR_W-1:0]   cfg_addr,
  input  logic [`LPIF_DELAY_W-1:0]      cfg_wdata,
  input  logic [`LPIF_CNT_W-1:0]        tx_count,
  input  logic [`LPIF_CNT_W-1:0]        rx_count,
  output lpif_link_pkg::link_cfg_t      cfg,
  output logic [`LPIF_DELAY_W-1:0]      cfg_rdata
);

  ////////////////////
  // Register writes

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      cfg <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        lpif_link_pkg::CFG_DELAY_X:  cfg.delay_x  <= cfg_wdata;
        lpif_link_pkg::CFG_DELAY_XZ: cfg.delay_xz <= cfg_wdata;
        lpif_link_pkg::CFG_DELAY_YZ: cfg.delay_yz <= cfg_wdata;
        lpif_link_pkg::CFG_USERBITS: begin
          cfg.mrk_userbit <= cfg_wdata[`LPIF_CH_N-1:0];
          cfg.stb_userbit <= cfg_wdata[`LPIF_CH_N];
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // Readback mux

  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      lpif_link_pkg::CFG_DELAY_X:  cfg_rdata = cfg.delay_x;
      lpif_link_pkg::CFG_DELAY_XZ: cfg_rdata = cfg.delay_xz;
      lpif_link_pkg::CFG_DELAY_YZ: cfg_rdata = cfg.delay_yz;
      lpif_link_pkg::CFG_USERBITS: begin
        cfg_rdata[`LPIF_CH_N-1:0] = cfg.mrk_userbit;
        cfg_rdata[`LPIF_CH_N]     = cfg.stb_userbit;
      end
      // Low byte of each flit counter
      lpif_link_pkg::CFG_TX_COUNT: cfg_rdata = tx_count[`LPIF_DELAY_W-1:0];
      lpif_link_pkg::CFG_RX_COUNT: cfg_rdata = rx_count[`LPIF_DELAY_W-1:0];
      default:                     cfg_rdata = '0;
    endcase
  end

endmodule

//--- design/lpif_auto_sync.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_auto_sync (
  input  logic                       clk_wr,
  input  logic                       reset,
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  lpif_link_pkg::link_cfg_t   cfg,
  output logic                       tx_online_delay,
  output logic                       rx_online_delay,
  output logic [`LPIF_CH_N-1:0]      mrk_bits,
  output logic                       stb_bit
);

  // One extra bit so the sum of two delays fits
  logic [`LPIF_DELAY_W:0] tx_cnt;
  logic [`LPIF_DELAY_W:0] tx_cnt_nxt;
  logic [`LPIF_DELAY_W:0] tx_target;
  logic [`LPIF_DELAY_W:0] rx_cnt;
  logic [`LPIF_DELAY_W:0] rx_cnt_nxt;
  logic [`LPIF_DELAY_W:0] rx_target;

  // Count up and hold at all ones
  function automatic logic [`LPIF_DELAY_W:0] sat_inc(input logic [`LPIF_DELAY_W:0] cnt);
    sat_inc = (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  assign tx_target  = {1'b0, cfg.delay_xz} + {1'b0, cfg.delay_yz};
  assign rx_target  = {1'b0, cfg.delay_x};
  assign tx_cnt_nxt = sat_inc(tx_cnt);
  assign rx_cnt_nxt = sat_inc(rx_cnt);

  ////////////////////
  // TX online delay

  // Counter includes the current online cycle, so the flag rises target cycles in
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      tx_cnt          <= tx_cnt_nxt;
      tx_online_delay <= (tx_cnt_nxt >= tx_target);
    end
  end

  ////////////////////
  // RX online delay

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      rx_cnt          <= rx_cnt_nxt;
      rx_online_delay <= (rx_cnt_nxt >= rx_target);
    end
  end

  ////////////////////
  // User bit selection

  // Persistent sync pattern until TX is online
  always_comb begin
    if (tx_online_delay) begin
      mrk_bits = cfg.mrk_userbit;
      stb_bit  = cfg.stb_userbit;
    end else begin
      mrk_bits = '1;
      stb_bit  = 1'b1;
    end
  end

endmodule

//--- design/lpif_flit_pack.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_flit_pack (
  input  logic                     clk_wr,
  input  logic                     reset,
  input  lpif_link_pkg::flit_t     dstrm,
  input  lpif_link_pkg::flit_t     rx_rec,
  input  logic                     tx_online_delay,
  input  logic                     rx_online_delay,
  output lpif_link_pkg::flit_t     tx_rec,
  output lpif_link_pkg::flit_t     ustrm,
  output logic [`LPIF_CNT_W-1:0]   tx_count,
  output logic [`LPIF_CNT_W-1:0]   rx_count
);

  ////////////////////
  // Downstream record

  // Zero record while the link is still syncing
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_rec <= '0;
    end else if (tx_online_delay) begin
      tx_rec <= dstrm;
    end else begin
      tx_rec <= '0;
    end
  end

  ////////////////////
  // Upstream gating

  always_comb begin
    if (rx_online_delay) begin
      ustrm = rx_rec;
    end else begin
      ustrm = '0;
    end
  end

  ////////////////////
  // Flit counters

  // Both counters wrap
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_count <= '0;
      rx_count <= '0;
    end else begin
      if (tx_online_delay && dstrm.valid) begin
        tx_count <= tx_count + 1'b1;
      end
      if (ustrm.valid) begin
        rx_count <= rx_count + 1'b1;
      end
    end
  end

endmodule

//--- design/lpif_phy_concat.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_phy_concat (
  input  logic                                        clk_wr,
  input  logic                                        reset,
  input  lpif_link_pkg::flit_t                        tx_rec,
  input  logic [`LPIF_CH_N-1:0]                       mrk_bits,
  input  logic                                        stb_bit,
  input  lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]   rx_phy,
  output lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]   tx_phy,
  output lpif_link_pkg::flit_t                        rx_rec
);

  // Record bits that spill into channel 1
  localparam int REC_W    = $bits(lpif_link_pkg::flit_t);
  localparam int REC_HI_W = REC_W - `LPIF_CH_PAY_W;

  lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0] tx_word;
  logic [REC_W-1:0]                          tx_bits;

  assign tx_bits = tx_rec;

  ////////////////////
  // Transmit words

  always_comb begin
    tx_word = '0;
    for (int ch = 0; ch < `LPIF_CH_N; ch++) begin
      tx_word[ch].fields.marker = mrk_bits[ch];
      tx_word[ch].fields.strobe = stb_bit;
    end
    // Channel 0 takes the low record bits
    tx_word[0].fields.payload = tx_bits[`LPIF_CH_PAY_W-1:0];
    // Channel 1 upper payload stays zero
    tx_word[1].fields.payload[REC_HI_W-1:0] = tx_bits[REC_W-1:`LPIF_CH_PAY_W];
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

  ////////////////////
  // Receive reassembly

  // Received marker and strobe are not used
  always_ff @(posedge clk_wr) begin
    rx_rec <= {rx_phy[1].fields.payload[REC_HI_W-1:0], rx_phy[0].fields.payload};
  end

endmodule

//--- design/lpif_link_top.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_link_top (
  input  logic                                        clk_wr,
  input  logic                                        reset,

  // Link state
  input  logic                                        tx_online,
  input  logic                                        rx_online,

  // User flits
  input  lpif_link_pkg::flit_t                        dstrm,
  output lpif_link_pkg::flit_t                        ustrm,

  // PHY channels
  output lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]   tx_phy,
  input  lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]   rx_phy,

  // Config bus
  input  logic                                        cfg_wr,
  input  logic [`LPIF_CFG_ADDR_W-1:0]                 cfg_addr,
  input  logic [`LPIF_DELAY_W-1:0]                    cfg_wdata,
  output logic [`LPIF_DELAY_W-1:0]                    cfg_rdata,

  output logic [`LPIF_CNT_W-1:0]                      tx_debug_status,
  output logic [`LPIF_CNT_W-1:0]                      rx_debug_status
);

  lpif_link_pkg::link_cfg_t  cfg;
  lpif_link_pkg::flit_t      tx_rec;
  lpif_link_pkg::flit_t      rx_rec;
  logic                      tx_online_delay;
  logic                      rx_online_delay;
  logic [`LPIF_CH_N-1:0]     mrk_bits;
  logic                      stb_bit;

  ////////////////////
  // Config and sync

  lpif_link_config u_config (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .tx_count   (tx_debug_status),
    .rx_count   (rx_debug_status),
    .cfg        (cfg),
    .cfg_rdata  (cfg_rdata)
  );

  lpif_auto_sync u_auto_sync (
    .clk_wr           (clk_wr),
    .reset            (reset),
    .tx_online        (tx_online),
    .rx_online        (rx_online),
    .cfg              (cfg),
    .tx_online_delay  (tx_online_delay),
    .rx_online_delay  (rx_online_delay),
    .mrk_bits         (mrk_bits),
    .stb_bit          (stb_bit)
  );

  ////////////////////
  // Data path

  lpif_flit_pack u_flit_pack (
    .clk_wr           (clk_wr),
    .reset            (reset),
    .dstrm            (dstrm),
    .rx_rec           (rx_rec),
    .tx_online_delay  (tx_online_delay),
    .rx_online_delay  (rx_online_delay),
    .tx_rec           (tx_rec),
    .ustrm            (ustrm),
    .tx_count         (tx_debug_status),
    .rx_count         (rx_debug_status)
  );

  lpif_phy_concat u_phy_concat (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .tx_rec    (tx_rec),
    .mrk_bits  (mrk_bits),
    .stb_bit   (stb_bit),
    .rx_phy    (rx_phy),
    .tx_phy    (tx_phy),
    .rx_rec    (rx_rec)
  );

endmodule

//--- dv/lpif_link_tb.sv
`timescale 1ns/1ps
`include "lpif_link_defines.svh"

module lpif_link_tb;

  localparam int FLIT_W  = $bits(lpif_link_pkg::flit_t);
  localparam int TIMEOUT = 64;

  logic                                       clk_wr;
  logic                                       reset;
  logic                                       tx_online;
  logic                                       rx_online;
  lpif_link_pkg::flit_t                       dstrm;
  lpif_link_pkg::flit_t                       ustrm;
  lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]  tx_phy;
  lpif_link_pkg::phy_word_u [`LPIF_CH_N-1:0]  rx_phy;
  logic                                       cfg_wr;
  logic [`LPIF_CFG_ADDR_W-1:0]                cfg_addr;
  logic [`LPIF_DELAY_W-1:0]                   cfg_wdata;
  logic [`LPIF_DELAY_W-1:0]                   cfg_rdata;
  logic [`LPIF_CNT_W-1:0]                     tx_debug_status;
  logic [`LPIF_CNT_W-1:0]                     rx_debug_status;

  int                      error_count   = 0;
  int                      timeout_count = 0;
  logic [31:0]             rng_state     = 32'h9dfe;
  logic [`LPIF_CNT_W-1:0]  valid_sent    = '0;
  logic [`LPIF_CH_N-1:0]   mrk_cfg       = 2'b01;
  logic                    stb_cfg       = 1'b0;
  // Flits on their way from dstrm to ustrm
  lpif_link_pkg::flit_t    inflight[$];

  // PHY loopback
  assign rx_phy = tx_phy;

  lpif_link_top dut (.*);

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  ////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic lpif_link_pkg::flit_t random_flit(input logic valid);
    lpif_link_pkg::flit_t f;
    logic [31:0]          r;
    r           = next_rand();
    f.state     = r[3:0];
    f.protid    = r[5:4];
    f.dvalid    = r[6];
    f.crc_valid = r[7];
    f.crc       = r[15:8];
    f.data      = {next_rand(), next_rand()};
    f.valid     = valid;
    return f;
  endfunction

  // Channel 0 gets flit bits 45:0, channel 1 the bits from 46 up
  function automatic logic [`LPIF_CH_PAY_W-1:0] layout_payload(
      input lpif_link_pkg::flit_t f, input int ch);
    logic [FLIT_W-1:0]         bits;
    logic [`LPIF_CH_PAY_W-1:0] pay;
    bits = f;
    pay  = '0;
    for (int i = 0; i < `LPIF_CH_PAY_W; i++) begin
      if (i + ch * `LPIF_CH_PAY_W < FLIT_W) pay[i] = bits[i + ch * `LPIF_CH_PAY_W];
    end
    return pay;
  endfunction

  function automatic lpif_link_pkg::phy_word_u make_word(
      input logic marker, input logic strobe, input logic [`LPIF_CH_PAY_W-1:0] payload);
    lpif_link_pkg::phy_word_u w;
    w.fields.marker  = marker;
    w.fields.strobe  = strobe;
    w.fields.payload = payload;
    return w;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_flit(input string name, input lpif_link_pkg::flit_t exp,
                            input lpif_link_pkg::flit_t act);
    if (act !== exp) begin
      error_count++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input lpif_link_pkg::phy_word_u exp,
                            input lpif_link_pkg::phy_word_u act);
    if (act !== exp) begin
      error_count++;
      $display("error %s: expected %h, actual %h", name, exp.raw, act.raw);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      error_count++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [`LPIF_CNT_W-1:0] exp,
                             input logic [`LPIF_CNT_W-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  ////////////////////
  // Directed tasks

  task automatic cfg_write(input logic [`LPIF_CFG_ADDR_W-1:0] addr, input logic [7:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    next_cycle();
    cfg_wr    = 1'b0;
  endtask

  task automatic cfg_read(input logic [`LPIF_CFG_ADDR_W-1:0] addr, output logic [7:0] data);
    cfg_addr = addr;
    #2;
    data = cfg_rdata;
    next_cycle();
  endtask

  // Drives one flit and remembers it for the ustrm compare
  task automatic send_flit(input lpif_link_pkg::flit_t f);
    dstrm = f;
    inflight.push_back(f);
    if (f.valid) valid_sent++;
  endtask

  // Loopback takes three cycles
  task automatic run_cycle(input string name, input lpif_link_pkg::flit_t f);
    lpif_link_pkg::flit_t exp;
    next_cycle();
    if (inflight.size() == 3) begin
      exp = inflight.pop_front();
      check_flit(name, exp, ustrm);
    end
    send_flit(f);
  endtask

  // Counts cycles until tx_phy shows the configured words (up) or the sync pattern
  task automatic wait_online(input logic up, input int exp_cycles);
    lpif_link_pkg::phy_word_u want [`LPIF_CH_N];
    lpif_link_pkg::phy_word_u sync;
    int                       cycles;
    logic                     done;
    sync   = make_word(1'b1, 1'b1, '0);
    cycles = 0;
    done   = 1'b0;
    for (int ch = 0; ch < `LPIF_CH_N; ch++) begin
      want[ch] = up ? make_word(mrk_cfg[ch], stb_cfg, '0) : sync;
    end
    for (int i = 0; i < TIMEOUT && !done; i++) begin
      next_cycle();
      if (tx_phy[0] === want[0] && tx_phy[1] === want[1]) begin
        done = 1'b1;
      end else begin
        cycles++;
        if (up) begin
          check_word("sync_ch0", sync, tx_phy[0]);
          check_word("sync_ch1", sync, tx_phy[1]);
        end
      end
    end
    if (!done) begin
      timeout_count++;
      $display("Timed out waiting for the user bits on tx_phy to change");
    end else begin
      check_count(up ? "online_delay" : "offline_delay", exp_cycles, cycles);
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    logic [7:0]           rd;
    lpif_link_pkg::flit_t known;
    reset     = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    dstrm     = '0;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (2) @(posedge clk_wr);
    #1;
    reset = 1'b0;
    check_word("reset_ch0", '0, tx_phy[0]);
    check_word("reset_ch1", '0, tx_phy[1]);
    check_flit("reset_ustrm", '0, ustrm);
    check_count("reset_tx_count", '0, tx_debug_status);
    check_count("reset_rx_count", '0, rx_debug_status);

    // Config readback
    cfg_write(lpif_link_pkg::CFG_DELAY_X, 8'h5a);
    cfg_write(lpif_link_pkg::CFG_DELAY_XZ, 8'hc3);
    cfg_write(lpif_link_pkg::CFG_DELAY_YZ, 8'h71);
    cfg_write(lpif_link_pkg::CFG_USERBITS, 8'h05);
    cfg_read(lpif_link_pkg::CFG_DELAY_X, rd);
    check_byte("cfg_delay_x", 8'h5a, rd);
    cfg_read(lpif_link_pkg::CFG_DELAY_XZ, rd);
    check_byte("cfg_delay_xz", 8'hc3, rd);
    cfg_read(lpif_link_pkg::CFG_DELAY_YZ, rd);
    check_byte("cfg_delay_yz", 8'h71, rd);
    cfg_read(lpif_link_pkg::CFG_USERBITS, rd);
    check_byte("cfg_userbits", 8'h05, rd);
    cfg_read(3'd6, rd);
    check_byte("cfg_unused", 8'h00, rd);

    // Online delay of 3 + 2 cycles for TX
    cfg_write(lpif_link_pkg::CFG_DELAY_X, 8'd4);
    cfg_write(lpif_link_pkg::CFG_DELAY_XZ, 8'd3);
    cfg_write(lpif_link_pkg::CFG_DELAY_YZ, 8'd2);
    cfg_write(lpif_link_pkg::CFG_USERBITS, {5'd0, stb_cfg, mrk_cfg});
    // Nonzero flit that must not reach tx_phy during sync
    dstrm     = random_flit(1'b0);
    tx_online = 1'b1;
    wait_online(1'b1, 5);

    // RX comes up later so its first flit meets a gated ustrm
    rx_online = 1'b1;
    dstrm     = random_flit(1'b0);
    for (int i = 0; i < 2; i++) run_cycle("rx_gate", random_flit(1'b0));
    next_cycle();
    check_flit("rx_gate", '0, ustrm);
    send_flit(random_flit(1'b0));

    // Back-to-back loopback
    for (int i = 0; i < 20; i++) run_cycle("loopback", random_flit(rng_state[20]));

    // PHY mapping of one known flit
    known = {4'ha, 2'b10, 64'h0123_4567_89ab_cdef, 1'b1, 8'h5c, 1'b1, 1'b1};
    run_cycle("mapping_loop", known);
    run_cycle("mapping_loop", '0);
    run_cycle("mapping_loop", '0);
    for (int ch = 0; ch < `LPIF_CH_N; ch++) begin
      check_word("phy_mapping", make_word(mrk_cfg[ch], stb_cfg, layout_payload(known, ch)),
                 tx_phy[ch]);
    end

    // Counters then offline gating
    for (int i = 0; i < 6; i++) run_cycle("count_loop", random_flit(1'b1));
    for (int i = 0; i < 5; i++) run_cycle("count_loop", random_flit(1'b0));
    for (int i = 0; i < 4; i++) run_cycle("count_loop", '0);
    check_count("tx_debug_status", valid_sent, tx_debug_status);
    check_count("rx_debug_status", valid_sent, rx_debug_status);
    cfg_read(lpif_link_pkg::CFG_TX_COUNT, rd);
    check_byte("cfg_tx_count", valid_sent[7:0], rd);
    cfg_read(lpif_link_pkg::CFG_RX_COUNT, rd);
    check_byte("cfg_rx_count", valid_sent[7:0], rd);
    tx_online = 1'b0;
    wait_online(1'b0, 1);
    for (int i = 0; i < 8; i++) begin
      dstrm = random_flit(1'b1);
      next_cycle();
      check_flit("offline_ustrm", '0, ustrm);
      check_word("offline_ch0", make_word(1'b1, 1'b1, '0), tx_phy[0]);
      check_word("offline_ch1", make_word(1'b1, 1'b1, '0), tx_phy[1]);
    end
    dstrm = '0;
    next_cycle();
    check_count("offline_tx_count", valid_sent, tx_debug_status);
    check_count("offline_rx_count", valid_sent, rx_debug_status);

    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+design
design/lpif_link_pkg.sv
design/lpif_link_config.sv
design/lpif_auto_sync.sv
design/lpif_flit_pack.sv
design/lpif_phy_concat.sv
design/lpif_link_top.sv
dv/lpif_link_tb.sv
